/* hw/blur_cfg.svh */
`ifndef BLUR_CFG_SVH
`define BLUR_CFG_SVH

// frame geometry, image is 640 x 480 handled as 40 columns of 16 pixels

// rows per column, also the address where a row pass ends
`define BLUR_ROWS       480

// 16-pixel columns across the frame
`define BLUR_COLS       40

// pixels per column and bits per pixel
`define BLUR_LANE_PX    16
`define BLUR_PX_BITS    8

// relay count at which the column preload ends
`define BLUR_COL_RELAY  2

// image and blur SRAM address width
`define BLUR_ADDR_BITS  9

`endif

/* hw/blur_pkg.sv */
`default_nettype none

`include "blur_cfg.svh"

package blur_pkg;

  // image or blur SRAM address
  typedef logic [`BLUR_ADDR_BITS-1:0] mem_addr_t;

  // current column index
  typedef logic [$clog2(`BLUR_COLS)-1:0] col_idx_t;

  // one column result, 16 pixels
  typedef logic [`BLUR_LANE_PX*`BLUR_PX_BITS-1:0] pix_word_t;

  // a full row word holding every column slot
  typedef logic [`BLUR_COLS*`BLUR_LANE_PX*`BLUR_PX_BITS-1:0] row_word_t;

  // cycles spent in the row phase, saturating
  typedef logic [2:0] row_age_t;

  // sweep states
  typedef enum logic [1:0] {
    st_idle,
    st_first_col,
    st_next_col,
    st_next_row
  } blur_state_t;

endpackage

`default_nettype wire

/* hw/blur_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "blur_cfg.svh"

module blur_sched (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start,
  input  wire                     row_done,
  output blur_pkg::blur_state_t   state,
  output blur_pkg::col_idx_t      col,
  output blur_pkg::row_age_t      row_age,
  output logic                    done
);

  blur_pkg::blur_state_t next_state;
  logic [1:0]            col_relay;
  logic                  in_preload;
  logic                  preload_end;
  logic                  last_col;

  assign in_preload  = (state == blur_pkg::st_first_col) || (state == blur_pkg::st_next_col);
  assign preload_end = in_preload && (col_relay == `BLUR_COL_RELAY);
  assign last_col    = (col == blur_pkg::col_idx_t'(`BLUR_COLS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= blur_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      blur_pkg::st_idle: begin
        if (start) begin
          next_state = blur_pkg::st_first_col;
        end
      end
      blur_pkg::st_first_col: begin
        if (preload_end) begin
          next_state = blur_pkg::st_next_row;
        end
      end
      blur_pkg::st_next_col: begin
        // last column finished, leave instead of preloading again
        if (done) begin
          next_state = blur_pkg::st_idle;
        end else if (preload_end) begin
          next_state = blur_pkg::st_next_row;
        end
      end
      blur_pkg::st_next_row: begin
        if (row_done) begin
          next_state = blur_pkg::st_next_col;
        end
      end
    endcase
  end

  // three-cycle preload, relay counts 0, 1, 2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_relay <= 2'd0;
    end else if (in_preload && col_relay < `BLUR_COL_RELAY) begin
      col_relay <= col_relay + 2'd1;
    end else if (!in_preload) begin
      col_relay <= 2'd0;
    end
  end

  // first column stays at 0, later ones step after their preload
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
    end else if (state == blur_pkg::st_idle || state == blur_pkg::st_first_col) begin
      col <= '0;
    end else if (state == blur_pkg::st_next_col && preload_end) begin
      col <= col + 1'b1;
    end
  end

  // saturates at 5, past the longest write lag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_age <= '0;
    end else if (state != blur_pkg::st_next_row) begin
      row_age <= '0;
    end else if (row_age < 3'd5) begin
      row_age <= row_age + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (state == blur_pkg::st_next_row && row_done && last_col) begin
      done <= 1'b1;
    end else if (state == blur_pkg::st_idle) begin
      done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/line_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "blur_cfg.svh"

module line_fetch (
  input  wire                     clk,
  input  wire                     rst_n,
  input  blur_pkg::blur_state_t   state,
  input  wire                     row_done,
  output blur_pkg::mem_addr_t     img_addr,
  output logic                    buffer_we,
  output logic                    fill_zero
);

  logic in_preload;
  logic in_row;
  logic addr_end;
  logic addr_end_q;

  assign in_preload = (state == blur_pkg::st_first_col) || (state == blur_pkg::st_next_col);
  assign in_row     = (state == blur_pkg::st_next_row);
  assign addr_end   = (img_addr == blur_pkg::mem_addr_t'(`BLUR_ROWS));

  // preload leaves the address above 0, so the row phase keeps counting on its own
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_addr <= '0;
    end else if (in_preload) begin
      img_addr <= img_addr + 1'b1;
    end else if (in_row && !addr_end && img_addr != '0) begin
      img_addr <= img_addr + 1'b1;
    end else if (in_row && row_done) begin
      img_addr <= '0;
    end else if (state == blur_pkg::st_idle) begin
      img_addr <= '0;
    end
  end

  // preload starts from address 0, so a nonzero address tracks relay above 0
  assign buffer_we = (in_preload && img_addr != '0) ||
                     (in_row && img_addr < blur_pkg::mem_addr_t'(`BLUR_ROWS));

  // pads the line buffer once in the cycle after the last row was fetched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_end_q <= 1'b0;
      fill_zero  <= 1'b0;
    end else begin
      addr_end_q <= addr_end;
      fill_zero  <= addr_end && !addr_end_q;
    end
  end

endmodule

`default_nettype wire

/* hw/row_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module row_merge (
  input  blur_pkg::col_idx_t    col,
  input  blur_pkg::pix_word_t   result,
  input  blur_pkg::row_word_t   stored,
  output blur_pkg::row_word_t   merged
);

  localparam int unsigned SLOT_BITS = $bits(blur_pkg::pix_word_t);
  localparam int unsigned LSB_W     = $clog2($bits(blur_pkg::row_word_t));

  logic [LSB_W-1:0]    slot_lsb;
  blur_pkg::row_word_t keep_mask;
  blur_pkg::row_word_t placed;

  // lowest bit of the slot that belongs to this column
  assign slot_lsb = LSB_W'(col * SLOT_BITS);

  // ones below the slot, earlier columns stay as stored
  assign keep_mask = (blur_pkg::row_word_t'(1) << slot_lsb) - blur_pkg::row_word_t'(1);

  // zero-extended result moved into its slot, clears everything above
  assign placed = blur_pkg::row_word_t'(result) << slot_lsb;

  assign merged = (stored & keep_mask) | placed;

endmodule

`default_nettype wire

/* hw/wb_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "blur_cfg.svh"

module wb_channel #(
  parameter int unsigned WE_LAG = 0
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  blur_pkg::blur_state_t   state,
  input  blur_pkg::col_idx_t      col,
  input  blur_pkg::row_age_t      row_age,
  input  blur_pkg::pix_word_t     blur_result,
  input  blur_pkg::row_word_t     blur_dout,
  output blur_pkg::mem_addr_t     blur_addr_r,
  output blur_pkg::mem_addr_t     blur_addr_w,
  output logic                    blur_mem_we,
  output blur_pkg::row_word_t     blur_din,
  output logic                    row_done
);

  localparam blur_pkg::mem_addr_t ROW_END = blur_pkg::mem_addr_t'(`BLUR_ROWS);

  logic                in_row;
  logic                col_clear;
  logic                lag_met;
  blur_pkg::mem_addr_t addr_w_next;
  blur_pkg::row_word_t merged;

  assign in_row    = (state == blur_pkg::st_next_row);
  assign col_clear = (state == blur_pkg::st_idle) || (state == blur_pkg::st_next_col);
  assign lag_met   = (row_age >= blur_pkg::row_age_t'(WE_LAG));

  // where the write address lands after this cycle
  assign addr_w_next = blur_addr_w + blur_pkg::mem_addr_t'(blur_mem_we);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_addr_r <= '0;
    end else if (col_clear) begin
      blur_addr_r <= '0;
    end else if (in_row && lag_met && blur_addr_r < ROW_END) begin
      blur_addr_r <= blur_addr_r + 1'b1;
    end
  end

  // look one write ahead so the last strobe lands on address 479
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_mem_we <= 1'b0;
    end else begin
      blur_mem_we <= in_row && lag_met && addr_w_next < ROW_END;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_addr_w <= '0;
    end else if (blur_mem_we && blur_addr_w < ROW_END) begin
      blur_addr_w <= blur_addr_w + 1'b1;
    end else if (col_clear) begin
      blur_addr_w <= '0;
    end
  end

  row_merge i_row_merge (
    .col    (col),
    .result (blur_result),
    .stored (blur_dout),
    .merged (merged)
  );

  always_ff @(posedge clk) begin
    if (in_row) begin
      blur_din <= merged;
    end
  end

  assign row_done = (blur_addr_w == ROW_END);

endmodule

`default_nettype wire

/* hw/blur_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module blur_ctrl_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   start,
  input  blur_pkg::pix_word_t   blur_result_0,
  input  blur_pkg::pix_word_t   blur_result_1,
  input  blur_pkg::pix_word_t   blur_result_2,
  input  blur_pkg::pix_word_t   blur_result_3,
  input  blur_pkg::row_word_t   blur_dout_0,
  input  blur_pkg::row_word_t   blur_dout_1,
  input  blur_pkg::row_word_t   blur_dout_2,
  input  blur_pkg::row_word_t   blur_dout_3,
  output logic                  done,
  output blur_pkg::mem_addr_t   img_addr,
  output logic                  buffer_we,
  output logic                  fill_zero,
  output blur_pkg::col_idx_t    current_col,
  output blur_pkg::mem_addr_t   blur_addr_r_0,
  output blur_pkg::mem_addr_t   blur_addr_r_1,
  output blur_pkg::mem_addr_t   blur_addr_r_2,
  output blur_pkg::mem_addr_t   blur_addr_r_3,
  output blur_pkg::mem_addr_t   blur_addr_w_0,
  output blur_pkg::mem_addr_t   blur_addr_w_1,
  output blur_pkg::mem_addr_t   blur_addr_w_2,
  output blur_pkg::mem_addr_t   blur_addr_w_3,
  output logic                  blur_mem_we_0,
  output logic                  blur_mem_we_1,
  output logic                  blur_mem_we_2,
  output logic                  blur_mem_we_3,
  output blur_pkg::row_word_t   blur_din_0,
  output blur_pkg::row_word_t   blur_din_1,
  output blur_pkg::row_word_t   blur_din_2,
  output blur_pkg::row_word_t   blur_din_3
);

  blur_pkg::blur_state_t state;
  blur_pkg::row_age_t    row_age;
  // channel 3 has the longest lag, so it closes the row
  logic                  row_done;

  blur_sched i_blur_sched (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .row_done (row_done),
    .state    (state),
    .col      (current_col),
    .row_age  (row_age),
    .done     (done)
  );

  line_fetch i_line_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .row_done  (row_done),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero)
  );

  // 3x3 kernel result
  wb_channel #(.WE_LAG(0)) i_wb_channel_0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .col         (current_col),
    .row_age     (row_age),
    .blur_result (blur_result_0),
    .blur_dout   (blur_dout_0),
    .blur_addr_r (blur_addr_r_0),
    .blur_addr_w (blur_addr_w_0),
    .blur_mem_we (blur_mem_we_0),
    .blur_din    (blur_din_0),
    .row_done    ()
  );

  // both 5x5 results share one lag
  wb_channel #(.WE_LAG(1)) i_wb_channel_1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .col         (current_col),
    .row_age     (row_age),
    .blur_result (blur_result_1),
    .blur_dout   (blur_dout_1),
    .blur_addr_r (blur_addr_r_1),
    .blur_addr_w (blur_addr_w_1),
    .blur_mem_we (blur_mem_we_1),
    .blur_din    (blur_din_1),
    .row_done    ()
  );

  wb_channel #(.WE_LAG(1)) i_wb_channel_2 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .col         (current_col),
    .row_age     (row_age),
    .blur_result (blur_result_2),
    .blur_dout   (blur_dout_2),
    .blur_addr_r (blur_addr_r_2),
    .blur_addr_w (blur_addr_w_2),
    .blur_mem_we (blur_mem_we_2),
    .blur_din    (blur_din_2),
    .row_done    ()
  );

  // 7x7 kernel result
  wb_channel #(.WE_LAG(2)) i_wb_channel_3 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .col         (current_col),
    .row_age     (row_age),
    .blur_result (blur_result_3),
    .blur_dout   (blur_dout_3),
    .blur_addr_r (blur_addr_r_3),
    .blur_addr_w (blur_addr_w_3),
    .blur_mem_we (blur_mem_we_3),
    .blur_din    (blur_din_3),
    .row_done    (row_done)
  );

endmodule

`default_nettype wire

/* bench/blur_tb_checks.svh */
`ifndef BLUR_TB_CHECKS_SVH
`define BLUR_TB_CHECKS_SVH

// 64-bit xorshift step for the stimulus tables
function automatic logic [63:0] xorshift64(input logic [63:0] x);
  logic [63:0] s;
  s = x ^ (x << 13);
  s = s ^ (s >> 7);
  s = s ^ (s << 17);
  return s;
endfunction

task automatic compare_word(input blur_pkg::row_word_t got, input blur_pkg::row_word_t exp,
                            input string what);
  blur_pkg::row_word_t diff;
  int                  first;
  check_count++;
  if (got !== exp) begin
    diff  = got ^ exp;
    first = -1;
    // lowest differing bit points at the slot that went wrong
    for (int b = $bits(diff) - 1; b >= 0; b--) begin
      if (diff[b]) begin
        first = b;
      end
    end
    error_count++;
    $display("** Error at %0t: %s, first differing bit %0d", $time, what, first);
  end
endtask

task automatic compare_addr(input blur_pkg::mem_addr_t got, input blur_pkg::mem_addr_t exp,
                            input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic compare_col(input blur_pkg::col_idx_t got, input blur_pkg::col_idx_t exp,
                           input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

`endif

/* bench/blur_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "blur_cfg.svh"

module blur_tb;

  localparam int CLK_PERIOD_NS = 10;
  localparam int ROWS          = `BLUR_ROWS;
  localparam int COLS          = `BLUR_COLS;
  localparam int SLOT_BITS     = `BLUR_LANE_PX * `BLUR_PX_BITS;
  localparam int ROW_BITS      = COLS * SLOT_BITS;
  localparam int TAIL_CYCLES   = 20;
  // room for 45 columns of 500 cycles each
  localparam int WATCHDOG_NS   = 45 * 500 * CLK_PERIOD_NS;

  logic                clk;
  logic                rst_n;
  logic                start;
  blur_pkg::pix_word_t result_in [4];
  blur_pkg::row_word_t dout_in [4];
  logic                done;
  blur_pkg::mem_addr_t img_addr;
  logic                buffer_we;
  logic                fill_zero;
  blur_pkg::col_idx_t  current_col;
  blur_pkg::mem_addr_t addr_r [4];
  blur_pkg::mem_addr_t addr_w [4];
  logic                mem_we [4];
  blur_pkg::row_word_t din [4];

  int check_count = 0;
  int error_count = 0;
  int test_count  = 0;

  // per column stimulus, one entry per channel
  blur_pkg::pix_word_t result_tab [4][COLS];
  blur_pkg::row_word_t dout_tab [4][COLS];

  // recorded during the sweep, checked afterwards
  int                 img_end_count [COLS];
  int                 fill_count [COLS];
  int                 bufwe_at_end = 0;
  int                 writes_after_done = 0;
  int                 writes_at_done [4];
  bit                 done_seen = 1'b0;
  blur_pkg::col_idx_t done_col;
  blur_pkg::col_idx_t col_trace [$];

  `include "blur_tb_checks.svh"

  blur_ctrl_top i_blur_ctrl_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .blur_result_0 (result_in[0]),
    .blur_result_1 (result_in[1]),
    .blur_result_2 (result_in[2]),
    .blur_result_3 (result_in[3]),
    .blur_dout_0   (dout_in[0]),
    .blur_dout_1   (dout_in[1]),
    .blur_dout_2   (dout_in[2]),
    .blur_dout_3   (dout_in[3]),
    .done          (done),
    .img_addr      (img_addr),
    .buffer_we     (buffer_we),
    .fill_zero     (fill_zero),
    .current_col   (current_col),
    .blur_addr_r_0 (addr_r[0]),
    .blur_addr_r_1 (addr_r[1]),
    .blur_addr_r_2 (addr_r[2]),
    .blur_addr_r_3 (addr_r[3]),
    .blur_addr_w_0 (addr_w[0]),
    .blur_addr_w_1 (addr_w[1]),
    .blur_addr_w_2 (addr_w[2]),
    .blur_addr_w_3 (addr_w[3]),
    .blur_mem_we_0 (mem_we[0]),
    .blur_mem_we_1 (mem_we[1]),
    .blur_mem_we_2 (mem_we[2]),
    .blur_mem_we_3 (mem_we[3]),
    .blur_din_0    (din[0]),
    .blur_din_1    (din[1]),
    .blur_din_2    (din[2]),
    .blur_din_3    (din[3])
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD_NS / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the column sweep did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  // earlier slots from the stored word, result in slot c, zeros above
  function automatic blur_pkg::row_word_t expected_row_word(input blur_pkg::pix_word_t result,
                                                            input blur_pkg::row_word_t stored,
                                                            input int c);
    blur_pkg::row_word_t w;
    w = '0;
    for (int s = 0; s < COLS; s++) begin
      if (s < c) begin
        w[s*SLOT_BITS +: SLOT_BITS] = stored[s*SLOT_BITS +: SLOT_BITS];
      end else if (s == c) begin
        w[s*SLOT_BITS +: SLOT_BITS] = result;
      end
    end
    return w;
  endfunction

  task automatic fill_tables();
    logic [63:0] rng;
    rng = 64'd95;
    for (int ch = 0; ch < 4; ch++) begin
      for (int c = 0; c < COLS; c++) begin
        for (int k = 0; k < SLOT_BITS / 64; k++) begin
          rng = xorshift64(rng);
          result_tab[ch][c][k*64 +: 64] = rng;
        end
        for (int k = 0; k < ROW_BITS / 64; k++) begin
          rng = xorshift64(rng);
          dout_tab[ch][c][k*64 +: 64] = rng;
        end
      end
    end
  endtask

  // inputs follow the column, so they only move when current_col does
  task automatic drive_inputs(input int c);
    if (c < COLS) begin
      for (int ch = 0; ch < 4; ch++) begin
        result_in[ch] = result_tab[ch][c];
        dout_in[ch]   = dout_tab[ch][c];
      end
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - errs_before);
  endtask

  task automatic test_reset_state();
    int errs_before;
    errs_before = error_count;
    @(negedge clk);
    compare_bit(done, 1'b0, "done after reset");
    compare_bit(buffer_we, 1'b0, "buffer_we after reset");
    compare_bit(fill_zero, 1'b0, "fill_zero after reset");
    compare_addr(img_addr, '0, "img_addr after reset");
    compare_col(current_col, '0, "current_col after reset");
    for (int ch = 0; ch < 4; ch++) begin
      compare_bit(mem_we[ch], 1'b0, $sformatf("channel %0d write enable after reset", ch));
      compare_addr(addr_r[ch], '0, $sformatf("channel %0d read address after reset", ch));
      compare_addr(addr_w[ch], '0, $sformatf("channel %0d write address after reset", ch));
    end
    report_test("reset state", errs_before);
  endtask

  // one full sweep, write order and merged words checked on every write
  task automatic run_sweep();
    int   errs_before;
    int   exp_w [4];
    int   c;
    int   tail;
    logic img_end;
    logic prev_img_end;
    logic prev_rise;
    errs_before  = error_count;
    tail         = 0;
    prev_img_end = 1'b0;
    prev_rise    = 1'b0;
    for (int ch = 0; ch < 4; ch++) begin
      exp_w[ch] = 0;
    end
    col_trace.push_back(current_col);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (tail < TAIL_CYCLES) begin
      c       = int'(current_col);
      img_end = (img_addr == blur_pkg::mem_addr_t'(ROWS));
      if (done_seen) begin
        tail++;
      end else if (c != int'(col_trace[$])) begin
        for (int ch = 0; ch < 4; ch++) begin
          compare_addr(blur_pkg::mem_addr_t'(exp_w[ch]), blur_pkg::mem_addr_t'(ROWS),
                       $sformatf("channel %0d writes in column %0d", ch, col_trace[$]));
          compare_addr(addr_r[ch], '0,
                       $sformatf("channel %0d read address at start of column %0d", ch, c));
          exp_w[ch] = 0;
        end
        col_trace.push_back(current_col);
      end
      for (int ch = 0; ch < 4; ch++) begin
        if (mem_we[ch]) begin
          if (done || done_seen) begin
            writes_after_done++;
          end
          compare_addr(addr_w[ch], blur_pkg::mem_addr_t'(exp_w[ch]),
                       $sformatf("channel %0d write address in column %0d", ch, c));
          // the read address runs one row ahead of the write
          compare_addr(addr_r[ch], blur_pkg::mem_addr_t'(exp_w[ch] + 1),
                       $sformatf("channel %0d read address in column %0d", ch, c));
          exp_w[ch]++;
          if (c < COLS) begin
            compare_word(din[ch], expected_row_word(result_tab[ch][c], dout_tab[ch][c], c),
                         $sformatf("channel %0d write word in column %0d", ch, c));
          end
        end
      end
      if (!done_seen && c < COLS) begin
        if (img_end && !prev_img_end) begin
          img_end_count[c]++;
        end
        if (fill_zero) begin
          fill_count[c]++;
        end
      end
      // fill_zero belongs to the cycle right after img_addr first hits the row end
      compare_bit(fill_zero, prev_rise, "fill_zero one cycle after img_addr reached the row end");
      if (buffer_we && img_end) begin
        bufwe_at_end++;
      end
      prev_rise    = img_end && !prev_img_end;
      prev_img_end = img_end;
      if (done && !done_seen) begin
        done_seen = 1'b1;
        done_col  = current_col;
        for (int ch = 0; ch < 4; ch++) begin
          writes_at_done[ch] = exp_w[ch];
        end
      end
      drive_inputs(c);
      @(negedge clk);
    end
    report_test("write addressing and merge", errs_before);
  endtask

  task automatic check_image_fetch();
    int errs_before;
    errs_before = error_count;
    for (int c = 0; c < COLS; c++) begin
      if (img_end_count[c] != 1) begin
        report_failure($sformatf("img_addr reached %0d %0d times in column %0d, expected once",
                                 ROWS, img_end_count[c], c));
      end
      if (fill_count[c] != 1) begin
        report_failure($sformatf("fill_zero was high %0d cycles in column %0d, expected one",
                                 fill_count[c], c));
      end
    end
    if (bufwe_at_end != 0) begin
      report_failure($sformatf("buffer_we was high in %0d cycles with img_addr at %0d",
                               bufwe_at_end, ROWS));
    end
    report_test("image fetch", errs_before);
  endtask

  task automatic check_column_sweep();
    int errs_before;
    errs_before = error_count;
    if (!done_seen) begin
      report_failure("done never rose during the sweep");
    end
    if (col_trace.size() != COLS) begin
      report_failure($sformatf("current_col took %0d values, expected %0d",
                               col_trace.size(), COLS));
    end
    for (int i = 0; i < col_trace.size(); i++) begin
      compare_col(col_trace[i], blur_pkg::col_idx_t'(i), $sformatf("column step %0d", i));
    end
    compare_col(done_col, blur_pkg::col_idx_t'(COLS - 1), "column when done rose");
    for (int ch = 0; ch < 4; ch++) begin
      compare_addr(blur_pkg::mem_addr_t'(writes_at_done[ch]), blur_pkg::mem_addr_t'(ROWS),
                   $sformatf("channel %0d writes of the last column when done rose", ch));
    end
    if (writes_after_done != 0) begin
      report_failure($sformatf("%0d writes happened after done rose", writes_after_done));
    end
    report_test("column sweep and done", errs_before);
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    fill_tables();
    drive_inputs(0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    run_sweep();
    check_image_fetch();
    check_column_sweep();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
+incdir+bench
hw/blur_pkg.sv
hw/blur_sched.sv
hw/line_fetch.sv
hw/row_merge.sv
hw/wb_channel.sv
hw/blur_ctrl_top.sv
bench/blur_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module blur_tb -o blur_sim &&
  ./obj_dir/blur_sim | tee /dev/stderr | grep -q "RESULT: PASS" ||
  { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
